// File: compile.f
+incdir+.
iadc_pkg.sv
iadc_ddr_capture.sv
iadc_word_assembler.sv
iadc_ctrl_port.sv
iadc_top.sv
iadc_tb.sv

// File: iadc_cfg.svh
`ifndef IADC_CFG_SVH
`define IADC_CFG_SVH

// converter sample width.
`define IADC_SAMPLE_W 8

// three-wire control register fields.
`define IADC_CTRL_ADDR_W 3
`define IADC_CTRL_DATA_W 16

// adc_clk cycles per half period of ctrl_clk.
`define IADC_CTRL_DIV 2

// ddrb reset pulse length in adc_clk cycles.
`define IADC_DDRB_CYCLES 8

`endif

// File: iadc_ctrl_port.sv
`timescale 1ns/1ns
`include "iadc_cfg.svh"

module iadc_ctrl_port (
  input  logic                 adc_clk,
  input  logic                 arst_n,
  input  logic                 ctrl_write,
  input  iadc_pkg::ctrl_addr_t ctrl_addr,
  input  iadc_pkg::ctrl_data_t ctrl_data,
  input  logic                 mode,
  input  logic                 ddrb_req,
  output logic                 ctrl_clk,
  output logic                 ctrl_sdata,
  output logic                 ctrl_strobe_n,
  output logic                 ctrl_busy,
  output logic                 adc_mode,
  output logic                 adc_ddrb
);
  import iadc_pkg::*;

  localparam int FRAME_W = $bits(ctrl_frame_t);
  localparam int BIT_W   = $clog2(FRAME_W);
  localparam int DIV_W   = $clog2(`IADC_CTRL_DIV + 1);
  localparam int DDRB_W  = $clog2(`IADC_DDRB_CYCLES + 1);

  ctrl_frame_t        frame_in;
  logic [FRAME_W-1:0] shreg;     // msb is on the pin.
  logic [BIT_W-1:0]   bit_cnt;   // bits left after the current one.
  logic [DIV_W-1:0]   div_cnt;
  logic               half_tick;
  logic [DDRB_W-1:0]  ddrb_cnt;

  assign frame_in.addr = ctrl_addr;
  assign frame_in.data = ctrl_data;

  assign half_tick  = (div_cnt == DIV_W'(`IADC_CTRL_DIV - 1));
  assign ctrl_sdata = shreg[FRAME_W-1];

  // data moves on the falling ctrl_clk, converter samples on the rise.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      shreg         <= '0;
      bit_cnt       <= '0;
      div_cnt       <= '0;
      ctrl_clk      <= 1'b0;
      ctrl_strobe_n <= 1'b1;
      ctrl_busy     <= 1'b0;
    end else if (!ctrl_busy) begin
      if (ctrl_write) begin
        shreg         <= frame_in;
        bit_cnt       <= BIT_W'(FRAME_W - 1);
        div_cnt       <= '0;
        ctrl_strobe_n <= 1'b0;
        ctrl_busy     <= 1'b1;
      end
    end else if (!half_tick) begin
      div_cnt <= div_cnt + 1'b1;
    end else begin
      div_cnt <= '0;
      if (!ctrl_clk) begin
        ctrl_clk <= 1'b1;
      end else begin
        ctrl_clk <= 1'b0;
        if (bit_cnt == '0) begin
          ctrl_strobe_n <= 1'b1;  // last bit sampled, close the frame.
          ctrl_busy     <= 1'b0;
        end else begin
          shreg   <= {shreg[FRAME_W-2:0], 1'b0};
          bit_cnt <= bit_cnt - 1'b1;
        end
      end
    end
  end

  // a request while counting restarts the pulse.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      ddrb_cnt <= '0;
    end else if (ddrb_req) begin
      ddrb_cnt <= DDRB_W'(`IADC_DDRB_CYCLES);
    end else if (ddrb_cnt != '0) begin
      ddrb_cnt <= ddrb_cnt - 1'b1;
    end
  end

  assign adc_ddrb = (ddrb_cnt != '0);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_mode <= 1'b0;
    end else begin
      adc_mode <= mode;  // one cycle behind.
    end
  end

endmodule

// File: iadc_ddr_capture.sv
`timescale 1ns/1ns

module iadc_ddr_capture #(
  parameter type lane_t = logic [7:0]
) (
  input  logic  adc_clk,
  input  logic  arst_n,
  input  lane_t d,
  output lane_t rise_q,
  output lane_t fall_q
);

  lane_t rise_r;  // first half of the pair.
  lane_t fall_r;  // second half of the pair.

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rise_r <= '0;
    end else begin
      rise_r <= d;
    end
  end

  // falling edge half.
  always_ff @(negedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      fall_r <= '0;
    end else begin
      fall_r <= d;
    end
  end

  // both halves retimed together onto the rising edge.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rise_q <= '0;
      fall_q <= '0;
    end else begin
      rise_q <= rise_r;
      fall_q <= fall_r;  // taken half a cycle after rise_r.
    end
  end

endmodule

// File: iadc_pkg.sv
`include "iadc_cfg.svh"

package iadc_pkg;

  typedef logic [`IADC_SAMPLE_W-1:0] sample_t;

  // the four lanes as they leave the pins, i_even on top.
  typedef struct packed {
    sample_t i_even;
    sample_t i_odd;
    sample_t q_even;
    sample_t q_odd;
  } data_lanes_t;

  typedef struct packed {
    logic i;  // out of range, i channel.
    logic q;  // out of range, q channel.
  } ovr_lanes_t;

  // packed output word, q channel in the upper half.
  typedef struct packed {
    sample_t q_even_r;
    sample_t q_odd_r;
    sample_t q_even_f;
    sample_t q_odd_f;
    sample_t i_even_r;
    sample_t i_odd_r;
    sample_t i_even_f;
    sample_t i_odd_f;
  } sample_word_t;

  typedef logic [`IADC_CTRL_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [`IADC_CTRL_DATA_W-1:0] ctrl_data_t;

  // serial frame, address goes out first.
  typedef struct packed {
    ctrl_addr_t addr;
    ctrl_data_t data;
  } ctrl_frame_t;

endpackage

// File: iadc_tb.sv
`timescale 1ns/1ns
`include "iadc_cfg.svh"

module iadc_tb;
  import iadc_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NROWS        = 24;
  localparam int NFIXED       = 8;
  localparam int FRAME_BITS   = `IADC_CTRL_ADDR_W + `IADC_CTRL_DATA_W;
  localparam int MAX_CYCLES   = RESET_CYCLES + NROWS + 4
                              + 2 * FRAME_BITS * `IADC_CTRL_DIV + `IADC_DDRB_CYCLES + 100;

  logic adc_clk, arst_n, sync_in, ovr_clear, ctrl_write, mode, ddrb_req;
  data_lanes_t  lanes_in;
  ovr_lanes_t   ovr_in;
  ctrl_addr_t   ctrl_addr;
  ctrl_data_t   ctrl_data;
  sample_word_t sample_word;
  logic [3:0]   ovr_word;
  logic [15:0]  word_count;
  logic [1:0]   ovr_sticky;
  logic sync_pulse, ctrl_clk, ctrl_sdata, ctrl_strobe_n, ctrl_busy, adc_mode, adc_ddrb;

  // stimulus columns and expected columns, one row per sample word.
  logic [31:0] tbl_rise [NROWS];
  logic [31:0] tbl_fall [NROWS];
  logic [1:0]  tbl_ovr_r [NROWS];
  logic [1:0]  tbl_ovr_f [NROWS];
  logic        tbl_sync [NROWS];
  logic        tbl_clr [NROWS];
  logic [63:0] exp_word [NROWS];
  logic [3:0]  exp_ovr [NROWS];
  logic        exp_pulse [NROWS];
  logic [15:0] exp_cnt [NROWS];
  logic        cnt_valid [NROWS];
  logic [1:0]  exp_sticky [NROWS];

  logic [31:0]         lfsr_state = 32'hddf;
  logic [FRAME_BITS-1:0] rx_frame;
  int mismatches = 0;
  int other_errors = 0;
  int rx_bits = 0;
  int frames = 0;
  int ddrb_high = 0;
  int cycles = 0;

  iadc_top dut0 (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // serial frame decode, converter side.
  always @(posedge ctrl_clk) begin
    if (!ctrl_strobe_n) begin
      rx_frame = {rx_frame[FRAME_BITS-2:0], ctrl_sdata};
      rx_bits++;
    end
  end

  always @(negedge ctrl_strobe_n) frames++;

  always @(negedge adc_clk) if (adc_ddrb === 1'b1) ddrb_high++;

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // lanes in: i_even 31:24, i_odd 23:16, q_even 15:8, q_odd 7:0.
  function automatic logic [63:0] pack_word(input logic [31:0] r, input logic [31:0] f);
    return {r[15:8], r[7:0], f[15:8], f[7:0], r[31:24], r[23:16], f[31:24], f[23:16]};
  endfunction

  task automatic set_row(input int k, input logic [31:0] r, input logic [31:0] f,
                         input logic [1:0] o_r, input logic [1:0] o_f,
                         input logic s, input logic c);
    tbl_rise[k]  = r;
    tbl_fall[k]  = f;
    tbl_ovr_r[k] = o_r;
    tbl_ovr_f[k] = o_f;
    tbl_sync[k]  = s;
    tbl_clr[k]   = c;
  endtask

  task automatic build_expected();
    logic prev_sync;
    logic seen;
    logic [15:0] cnt;
    logic [1:0] sticky;
    logic [1:0] hit;
    prev_sync = 1'b0;
    seen = 1'b0;
    cnt = '0;
    sticky = '0;
    for (int k = 0; k < NROWS; k++) begin
      exp_word[k]  = pack_word(tbl_rise[k], tbl_fall[k]);
      exp_ovr[k]   = {tbl_ovr_f[k], tbl_ovr_r[k]};
      exp_pulse[k] = tbl_sync[k] & ~prev_sync;  // first high sync of a run.
      prev_sync    = tbl_sync[k];
      if (exp_pulse[k]) begin
        cnt  = '0;
        seen = 1'b1;
      end else begin
        cnt = cnt + 16'd1;
      end
      exp_cnt[k]   = cnt;
      cnt_valid[k] = seen;
      hit    = tbl_ovr_r[k] | tbl_ovr_f[k];
      sticky = tbl_clr[k] ? hit : (sticky | hit);
      exp_sticky[k] = sticky;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_row(input int k);
    check_value("sample_word", sample_word, exp_word[k]);
    check_value("ovr_word", {60'd0, ovr_word}, {60'd0, exp_ovr[k]});
    check_value("sync_pulse", {63'd0, sync_pulse}, {63'd0, exp_pulse[k]});
    if (cnt_valid[k]) check_value("word_count", {48'd0, word_count}, {48'd0, exp_cnt[k]});
    check_value("ovr_sticky", {62'd0, ovr_sticky}, {62'd0, exp_sticky[k]});
  endtask

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge adc_clk);
      cycles++;
    end
    other_errors++;
    $display("timeout: run still going after %0d cycles", MAX_CYCLES);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    lanes_in = '0;
    ovr_in = '0;
    sync_in = 1'b0;
    ovr_clear = 1'b0;
    ctrl_write = 1'b0;
    ctrl_addr = '0;
    ctrl_data = '0;
    mode = 1'b0;
    ddrb_req = 1'b0;
    set_row(0, 32'h11223344, 32'h55667788, 2'b00, 2'b00, 1'b0, 1'b0);
    set_row(1, 32'hA0A1A2A3, 32'hB0B1B2B3, 2'b10, 2'b00, 1'b0, 1'b0);
    set_row(2, 32'h00FF00FF, 32'hFF00FF00, 2'b00, 2'b01, 1'b1, 1'b0);
    set_row(3, 32'hDEADBEEF, 32'hCAFEF00D, 2'b00, 2'b00, 1'b1, 1'b0);
    set_row(4, 32'h01020304, 32'h05060708, 2'b00, 2'b00, 1'b0, 1'b1);
    set_row(5, 32'h7F807F80, 32'h807F807F, 2'b01, 2'b00, 1'b0, 1'b1);  // set beats clear.
    set_row(6, 32'hC3C3C3C3, 32'h3C3C3C3C, 2'b00, 2'b00, 1'b0, 1'b0);
    set_row(7, 32'h89ABCDEF, 32'h76543210, 2'b00, 2'b00, 1'b0, 1'b1);
    for (int k = NFIXED; k < NROWS; k++) begin
      set_row(k, next_bits(32), next_bits(32), next_bits(2), next_bits(2),
              next_bits(1), next_bits(1));
    end
    build_expected();

    repeat (RESET_CYCLES) @(posedge adc_clk);
    #1 arst_n = 1'b1;
    @(negedge adc_clk);
    check_value("ctrl_strobe_n", {63'd0, ctrl_strobe_n}, 64'd1);
    check_value("ctrl_clk", {63'd0, ctrl_clk}, 64'd0);
    check_value("ctrl_busy", {63'd0, ctrl_busy}, 64'd0);
    check_value("adc_ddrb", {63'd0, adc_ddrb}, 64'd0);
    check_value("sync_pulse", {63'd0, sync_pulse}, 64'd0);
    check_value("sample_word", sample_word, 64'd0);
    check_value("ovr_sticky", {62'd0, ovr_sticky}, 64'd0);

    @(posedge adc_clk);
    #1 sync_in = tbl_sync[0];
    // rise half goes out after the falling edge so it is stable at the next rising edge.
    for (int c = 0; c < NROWS + 3; c++) begin
      @(negedge adc_clk);
      if (c >= 3) check_row(c - 3);
      #1;
      lanes_in = (c < NROWS) ? tbl_rise[c] : '0;
      ovr_in   = (c < NROWS) ? tbl_ovr_r[c] : '0;
      @(posedge adc_clk);
      #1;
      lanes_in  = (c < NROWS) ? tbl_fall[c] : '0;
      ovr_in    = (c < NROWS) ? tbl_ovr_f[c] : '0;
      sync_in   = (c + 1 < NROWS) ? tbl_sync[c+1] : 1'b0;
      ovr_clear = (c >= 1 && c <= NROWS) ? tbl_clr[c-1] : 1'b0;  // lands with its word.
    end

    @(posedge adc_clk);
    #1 ctrl_addr = 3'h5;
    ctrl_data = 16'hA3C6;
    ctrl_write = 1'b1;
    @(posedge adc_clk);
    #1 ctrl_write = 1'b0;
    check_value("ctrl_busy", {63'd0, ctrl_busy}, 64'd1);
    repeat (10) @(posedge adc_clk);
    #1 ctrl_addr = 3'h2;  // lands while busy.
    ctrl_data = 16'h1234;
    ctrl_write = 1'b1;
    @(posedge adc_clk);
    #1 ctrl_write = 1'b0;
    while (ctrl_busy) @(negedge adc_clk);
    repeat (8) @(negedge adc_clk);
    check_value("frames", frames, 64'd1);
    check_value("frame_bits", rx_bits, FRAME_BITS);
    check_value("ctrl_frame", {45'd0, rx_frame}, {45'd0, 3'h5, 16'hA3C6});
    check_value("ctrl_strobe_n", {63'd0, ctrl_strobe_n}, 64'd1);

    @(posedge adc_clk);
    #1 ddrb_req = 1'b1;
    mode = 1'b1;
    @(negedge adc_clk);
    check_value("adc_mode", {63'd0, adc_mode}, 64'd0);
    check_value("adc_ddrb", {63'd0, adc_ddrb}, 64'd0);
    @(posedge adc_clk);
    #1 ddrb_req = 1'b0;
    @(negedge adc_clk);
    check_value("adc_mode", {63'd0, adc_mode}, 64'd1);
    check_value("adc_ddrb", {63'd0, adc_ddrb}, 64'd1);
    while (adc_ddrb) @(negedge adc_clk);
    repeat (4) @(negedge adc_clk);
    check_value("ddrb_cycles", ddrb_high, `IADC_DDRB_CYCLES);

    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: iadc_top.sv
`timescale 1ns/1ns

module iadc_top (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  input  iadc_pkg::data_lanes_t  lanes_in,
  input  iadc_pkg::ovr_lanes_t   ovr_in,
  input  logic                   sync_in,
  input  logic                   ovr_clear,
  input  logic                   ctrl_write,
  input  iadc_pkg::ctrl_addr_t   ctrl_addr,
  input  iadc_pkg::ctrl_data_t   ctrl_data,
  input  logic                   mode,
  input  logic                   ddrb_req,
  output iadc_pkg::sample_word_t sample_word,
  output logic [3:0]             ovr_word,
  output logic                   sync_pulse,
  output logic [15:0]            word_count,
  output logic [1:0]             ovr_sticky,
  output logic                   ctrl_clk,
  output logic                   ctrl_sdata,
  output logic                   ctrl_strobe_n,
  output logic                   ctrl_busy,
  output logic                   adc_mode,
  output logic                   adc_ddrb
);
  import iadc_pkg::*;

  data_lanes_t data_rise;
  data_lanes_t data_fall;
  ovr_lanes_t  ovr_rise;
  ovr_lanes_t  ovr_fall;

  // data lanes.
  iadc_ddr_capture #(.lane_t(data_lanes_t)) cap_data (
    .adc_clk (adc_clk),
    .arst_n  (arst_n),
    .d       (lanes_in),
    .rise_q  (data_rise),
    .fall_q  (data_fall)
  );

  // out of range lines.
  iadc_ddr_capture #(.lane_t(ovr_lanes_t)) cap_ovr (
    .adc_clk (adc_clk),
    .arst_n  (arst_n),
    .d       (ovr_in),
    .rise_q  (ovr_rise),
    .fall_q  (ovr_fall)
  );

  iadc_word_assembler u_asm (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .sync_in     (sync_in),
    .data_rise   (data_rise),
    .data_fall   (data_fall),
    .ovr_rise    (ovr_rise),
    .ovr_fall    (ovr_fall),
    .ovr_clear   (ovr_clear),
    .sample_word (sample_word),
    .ovr_word    (ovr_word),
    .sync_pulse  (sync_pulse),
    .word_count  (word_count),
    .ovr_sticky  (ovr_sticky)
  );

  iadc_ctrl_port u_ctrl (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .ctrl_write    (ctrl_write),
    .ctrl_addr     (ctrl_addr),
    .ctrl_data     (ctrl_data),
    .mode          (mode),
    .ddrb_req      (ddrb_req),
    .ctrl_clk      (ctrl_clk),
    .ctrl_sdata    (ctrl_sdata),
    .ctrl_strobe_n (ctrl_strobe_n),
    .ctrl_busy     (ctrl_busy),
    .adc_mode      (adc_mode),
    .adc_ddrb      (adc_ddrb)
  );

endmodule

// File: iadc_word_assembler.sv
`timescale 1ns/1ns

module iadc_word_assembler (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  input  logic                   sync_in,
  input  iadc_pkg::data_lanes_t  data_rise,
  input  iadc_pkg::data_lanes_t  data_fall,
  input  iadc_pkg::ovr_lanes_t   ovr_rise,
  input  iadc_pkg::ovr_lanes_t   ovr_fall,
  input  logic                   ovr_clear,
  output iadc_pkg::sample_word_t sample_word,
  output logic [3:0]             ovr_word,
  output logic                   sync_pulse,
  output logic [15:0]            word_count,
  output logic [1:0]             ovr_sticky
);
  import iadc_pkg::*;

  sample_word_t word_next;
  logic [3:0]   ovr_next;
  logic [1:0]   ovr_hit;    // i in bit 1.
  logic         sync_r;     // sync_in, same edge as rise data.
  logic         sync_q;
  logic         sync_edge;  // in step with rise_q of the capture.

  always_comb begin
    word_next.q_even_r = data_rise.q_even;
    word_next.q_odd_r  = data_rise.q_odd;
    word_next.q_even_f = data_fall.q_even;
    word_next.q_odd_f  = data_fall.q_odd;
    word_next.i_even_r = data_rise.i_even;
    word_next.i_odd_r  = data_rise.i_odd;
    word_next.i_even_f = data_fall.i_even;
    word_next.i_odd_f  = data_fall.i_odd;
  end

  // fall pair above rise pair.
  assign ovr_next = {ovr_fall.i, ovr_fall.q, ovr_rise.i, ovr_rise.q};
  assign ovr_hit  = {ovr_next[3] | ovr_next[1], ovr_next[2] | ovr_next[0]};

  // edge detect runs one stage ahead so the pulse lands on its word.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_r    <= 1'b0;
      sync_q    <= 1'b0;
      sync_edge <= 1'b0;
    end else begin
      sync_r    <= sync_in;
      sync_q    <= sync_r;
      sync_edge <= sync_r & ~sync_q;
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      sample_word <= '0;
      ovr_word    <= '0;
      sync_pulse  <= 1'b0;
      word_count  <= '0;
    end else begin
      sample_word <= word_next;
      ovr_word    <= ovr_next;
      sync_pulse  <= sync_edge;
      if (sync_edge) begin
        word_count <= '0;  // restart on the sync word.
      end else begin
        word_count <= word_count + 16'd1;  // wraps.
      end
    end
  end

  // a new hit beats a clear in the same cycle.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      ovr_sticky <= '0;
    end else if (ovr_clear) begin
      ovr_sticky <= ovr_hit;
    end else begin
      ovr_sticky <= ovr_sticky | ovr_hit;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the iadc testbench with Verilator.
set -u

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
  -f compile.f --top-module iadc_tb -o iadc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/iadc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
  exit 0
fi
exit 1
